/* apu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module apu_alu (
	input  logic [apu_cfg_pkg::data_w-1:0] arg0,
	input  logic [apu_cfg_pkg::data_w-1:0] arg1,
	input  logic                           c,
	input  apu_isa_pkg::apu_func_e         func,
	input  apu_isa_pkg::apu_sz_e           sz,
	output logic [apu_cfg_pkg::data_w-1:0] res,
	output logic                           fc,
	output logic                           fz,
	output logic                           fs,
	output logic                           fv
);
	import apu_cfg_pkg::*;
	import apu_isa_pkg::*;

	localparam int tw = $clog2(data_w);

	logic [data_w-1:0] msk;
	logic [tw-1:0]     top;	// Top bit index at the operand size
	logic [tw-1:0]     ftop;	// Same, but products are twice as wide
	logic [data_w-1:0] src_sz;
	logic [data_w-1:0] arg_sz;
	logic              sc;
	logic [data_w:0]   sum;
	logic [data_w:0]   dif;
	logic              cl;
	logic              lc;
	logic              rc;
	logic [data_w-1:0] r_rr;
	logic [data_w-1:0] r_rl;
	logic              sg;
	logic [data_w-1:0] mul_a;
	logic [data_w-1:0] mul_b;
	logic [data_w-1:0] prod;
	logic [data_w-1:0] r_mul;
	logic              is_mul;

	always_comb begin
		unique case (sz)
			sz_8: begin
				msk = data_w'('hff);
				top = tw'(7);
			end
			sz_16: begin
				msk = data_w'('hffff);
				top = tw'(15);
			end
			sz_24: begin
				msk = data_w'('hff_ffff);
				top = tw'(23);
			end
			sz_32: begin
				msk = '1;
				top = tw'(data_w - 1);
			end
		endcase
	end

	assign src_sz = arg0 & msk;
	assign arg_sz = arg1 & msk;

	// Carry in only for adc and sbc
	assign sc  = c & func[0];
	assign sum = {1'b0, src_sz} + {1'b0, arg_sz} + (data_w + 1)'(sc);
	assign dif = {1'b0, src_sz} - {1'b0, arg_sz} - (data_w + 1)'(sc);

	assign cl = arg1[top];	// Leaves on left shifts
	assign lc = func[0] ? c : cl;	// rlc takes old C

	always_comb begin
		case (func[1:0])
			2'b00:   rc = arg1[0];	// rr
			2'b01:   rc = c;	// rrc
			2'b10:   rc = cl;	// sra keeps sign
			default: rc = 1'b0;	// srz
		endcase
	end

	always_comb begin
		r_rr      = arg_sz >> 1;
		r_rr[top] = rc;	// Insert at the size's top bit
	end

	assign r_rl = ((arg_sz << 1) | data_w'(lc)) & msk;

	// Byte operands give a 16-bit product, all others use 16-bit operands
	assign sg = func[0];
	always_comb begin
		if (sz == sz_8) begin
			mul_a = {{(data_w - 8){arg0[7] & sg}}, arg0[7:0]};
			mul_b = {{(data_w - 8){arg1[7] & sg}}, arg1[7:0]};
		end else begin
			mul_a = {{(data_w - 16){arg0[15] & sg}}, arg0[15:0]};
			mul_b = {{(data_w - 16){arg1[15] & sg}}, arg1[15:0]};
		end
		prod  = mul_a * mul_b;
		r_mul = (sz == sz_8) ? (prod & data_w'('hffff)) : prod;
	end

	assign is_mul = func inside {f_mul, f_muls};
	assign ftop   = !is_mul ? top : (sz == sz_8) ? tw'(15) : tw'(data_w - 1);

	always_comb begin
		case (func)
			f_load:                    res = arg_sz;
			f_and:                     res = src_sz & arg_sz;
			f_or:                      res = src_sz | arg_sz;
			f_xor:                     res = src_sz ^ arg_sz;
			f_add, f_adc:              res = sum[data_w-1:0] & msk;
			f_sub, f_sbc:              res = dif[data_w-1:0] & msk;
			f_rr, f_rrc, f_sra, f_srz: res = r_rr;
			f_rl, f_rlc:               res = r_rl;
			default:                   res = r_mul;
		endcase
	end

	assign fz = res == '0;	// Result is already masked
	assign fs = res[ftop];

	always_comb begin
		case (func)
			f_add, f_adc:              fc = sum[int'(top) + 1];
			f_sub, f_sbc:              fc = dif[int'(top) + 1];	// Borrow
			f_rr, f_rrc, f_sra, f_srz: fc = arg1[0];
			f_rl, f_rlc:               fc = cl;
			f_mul, f_muls:             fc = fs;
			default:                   fc = 1'b0;
		endcase
	end

	// Signed overflow from the operand and result signs
	always_comb begin
		case (func)
			f_add, f_adc: fv = (src_sz[top] == arg_sz[top]) && (res[top] != src_sz[top]);
			f_sub, f_sbc: fv = (src_sz[top] != arg_sz[top]) && (res[top] != src_sz[top]);
			default:      fv = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* apu_cfg_pkg.sv */
`default_nettype none

package apu_cfg_pkg;

	// Datapath wide enough for every operand size
	localparam int data_w = 32;

	// 64 program RAM words
	localparam int prog_aw = 6;

	// 32 data RAM words
	localparam int dat_aw = 5;

	// Eight general registers
	localparam int reg_aw = 3;

	localparam int cnt_w = 16;	// Loop counter

endpackage

`default_nettype wire

/* apu_isa_pkg.sv */
`default_nettype none

package apu_isa_pkg;

	typedef enum logic [3:0] {
		k_alu_rr = 4'd0,	// rd = rd op rs
		k_alu_ri = 4'd1,	// rd = rd op imm
		k_st     = 4'd2,	// dat[imm] = rs
		k_lpset  = 4'd3,	// cnt = imm
		k_djnz   = 4'd4,	// --cnt, jump while non-zero
		k_jc     = 4'd5,
		k_jz     = 4'd6,
		k_jmp    = 4'd7,
		k_halt   = 4'd8
	} apu_kind_e;

	// Bits 3:2 select the group, bits 1:0 the variant
	typedef enum logic [3:0] {
		f_load = 4'd0,
		f_and  = 4'd1,
		f_or   = 4'd2,
		f_xor  = 4'd3,
		f_add  = 4'd4,
		f_adc  = 4'd5,
		f_sub  = 4'd6,
		f_sbc  = 4'd7,
		f_rr   = 4'd8,
		f_rrc  = 4'd9,
		f_sra  = 4'd10,
		f_srz  = 4'd11,
		f_rl   = 4'd12,
		f_rlc  = 4'd13,
		f_mul  = 4'd14,
		f_muls = 4'd15
	} apu_func_e;

	typedef enum logic [1:0] {
		sz_8  = 2'd0,
		sz_16 = 2'd1,
		sz_24 = 2'd2,
		sz_32 = 2'd3
	} apu_sz_e;

	// kind in bits 31:28, imm in bits 15:0
	typedef struct packed {
		apu_kind_e   kind;
		apu_func_e   func;
		apu_sz_e     sz;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic [15:0] imm;
	} apu_insn_t;

endpackage

`default_nettype wire

/* apu_loop_cnt.sv */
`timescale 1ns/10ps
`default_nettype none

module apu_loop_cnt #(
	parameter int width = 16
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic             dec,
	input  logic [width-1:0] val,
	output logic             cnt_zero
);

	logic [width-1:0] cnt;
	logic [width-1:0] cnt_nxt;

	always_comb begin
		if (load) begin
			cnt_nxt = val;	// Load wins over dec
		end else if (dec) begin
			cnt_nxt = cnt - 1'b1;
		end else begin
			cnt_nxt = cnt;
		end
	end

	// Look-ahead so djnz can branch in the same EXEC
	assign cnt_zero = cnt_nxt == '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else begin
			cnt <= cnt_nxt;
		end
	end

endmodule

`default_nettype wire

/* apu_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module apu_ram #(
	parameter type word_t = logic [31:0],
	parameter int  aw     = 6
) (
	input  logic          clk,
	input  logic          we,
	input  logic [aw-1:0] waddr,
	input  word_t         wdata,
	input  logic [aw-1:0] raddr,
	output word_t         rdata
);

	word_t mem [0:(1 << aw) - 1];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];	// Old word on a same-address write
	end

endmodule

`default_nettype wire

/* apu_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module apu_regs #(
	parameter int aw = 3
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           we,
	input  logic [aw-1:0]                  widx,
	input  logic [apu_cfg_pkg::data_w-1:0] wdata,
	input  logic [aw-1:0]                  ra_idx,
	input  logic [aw-1:0]                  rb_idx,
	output logic [apu_cfg_pkg::data_w-1:0] ra,
	output logic [apu_cfg_pkg::data_w-1:0] rb
);
	import apu_cfg_pkg::*;

	logic [data_w-1:0] regs [0:(1 << aw) - 1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << aw); i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[widx] <= wdata;
		end
	end

	// Read ports see the value before this cycle's write
	assign ra = regs[ra_idx];
	assign rb = regs[rb_idx];

endmodule

`default_nettype wire

/* apu_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module apu_seq #(
	parameter int prog_aw = 6
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  apu_isa_pkg::apu_insn_t insn,
	input  logic                   cnt_zero,
	input  logic                   alu_fc,
	input  logic                   alu_fz,
	input  logic                   alu_fs,
	input  logic                   alu_fv,
	output logic [prog_aw-1:0]     pc,
	output logic                   busy,
	output logic                   done,
	output logic                   reg_we,
	output apu_isa_pkg::apu_func_e alu_func,
	output apu_isa_pkg::apu_sz_e   alu_sz,
	output logic                   use_imm,
	output logic                   c_in,
	output logic                   cnt_load,
	output logic                   cnt_dec,
	output logic                   dat_we,
	output logic [3:0]             flags
);
	import apu_isa_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_fetch,	// Program RAM read in flight
		s_exec
	} state_e;

	state_e             state;
	logic               exec;
	logic               is_alu;
	logic               take;
	logic [prog_aw-1:0] target;
	logic               fl_c;
	logic               fl_z;
	logic               fl_s;
	logic               fl_v;

	assign exec   = state == s_exec;
	assign is_alu = insn.kind inside {k_alu_rr, k_alu_ri};
	assign target = insn.imm[prog_aw-1:0];

	always_comb begin
		case (insn.kind)
			k_djnz:  take = !cnt_zero;	// Count after this decrement
			k_jc:    take = fl_c;
			k_jz:    take = fl_z;
			k_jmp:   take = 1'b1;
			default: take = 1'b0;
		endcase
	end

	// Strobes only in EXEC where insn is valid
	assign reg_we   = exec && is_alu;
	assign dat_we   = exec && (insn.kind == k_st);
	assign cnt_load = exec && (insn.kind == k_lpset);
	assign cnt_dec  = exec && (insn.kind == k_djnz);

	assign alu_func = insn.func;
	assign alu_sz   = insn.sz;
	assign use_imm  = insn.kind == k_alu_ri;
	assign c_in     = fl_c;

	assign busy  = state != s_idle;
	assign flags = {fl_c, fl_z, fl_s, fl_v};	// C in bit 3, V in bit 0

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_idle;
			pc    <= '0;
			done  <= 1'b0;
			fl_c  <= 1'b0;
			fl_z  <= 1'b0;
			fl_s  <= 1'b0;
			fl_v  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				s_idle: begin
					if (start) begin
						pc    <= '0;
						fl_c  <= 1'b0;	// Each run starts from clean flags
						fl_z  <= 1'b0;
						fl_s  <= 1'b0;
						fl_v  <= 1'b0;
						state <= s_fetch;
					end
				end
				s_fetch: state <= s_exec;
				s_exec: begin
					if (is_alu) begin
						fl_c <= alu_fc;
						fl_z <= alu_fz;
						fl_s <= alu_fs;
						fl_v <= alu_fv;
					end
					if (insn.kind == k_halt) begin
						state <= s_idle;
						done  <= 1'b1;
					end else begin
						pc    <= take ? target : pc + 1'b1;
						state <= s_fetch;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* apu_testdata.txt */
// Hex words: test count, then per test the insn count and insns,
// the check count with (address, expected word) pairs, and flags {C,Z,S,V}
00000006
// Load and logic at all four sizes
00000014
10C80000 16C80001 00990000 20030000 00610000 20040001 00290000 20050002
00F10000 11705A3C 20060003 10D05A3C 03CA0000 20010004 10F800F0 12380F0F
20070006 01890000 20010005 80000000
00000007
00000000 00FFFFFF 00000001 0000FFFF 00000002 000000FF 00000003 00005A3C
00000004 FFFFA5C3 00000005 00FFA5C3 00000006 000000FF
00000002
// Add and subtract chains with jc taken and not taken
00000017
10C800FF 10D0FFFF 14080001 50000005 80000000 15500010 20020008 10D80000
16980001 15980002 20030009 5000000D 80000000 10E00000 16E00001 17E00001
2004000A 50000013 2004000B 10E8007F 14280001 2005000C 80000000
00000005
00000008 00000010 00000009 00000002 0000000A FFFFFFFD 0000000B FFFFFFFD
0000000C 00000080
00000003
// Rotates and shifts
00000010
18080081 20010010 19500002 20020011 10D80000 16980002 0AA30000 20040012
0BEC0000 20050013 1C708001 20060014 0DBB0000 20070015 1B080001 80000000
00000006
00000010 000000C0 00000011 00008001 00000012 00FFFFFF 00000013 007FFFFF
00000014 00000003 00000015 00FFFFFD
0000000C
// Unsigned and signed multiply
00000014
10C800FE 1F080005 20010018 10D000FE 1E100005 20020019 10D8FFFF 10E08000
0F5C0000 2003001A 10E8FFFE 1F680003 2005001B 10F80080 1F3800FF 2007001C
10F0FFFF 0E760000 2006001D 80000000
00000006
00000018 0000FFF6 00000019 000004F6 0000001A 00008000 0000001B FFFFFFFA
0000001C 00000080 0000001D FFFE0001
0000000A
// Counted loop summing 1 to 20, then jz and jmp
00000010
10C80000 10D00000 30000014 14D00001 04CA0000 40000003 2001001E 6000000B
10D800D2 06D90000 6000000C 80000000 7000000E 80000000 2002001F 80000000
00000002
0000001E 000000D2 0000001F 00000014
00000004
// Reloaded program overwrites address 0
00000003
10C81234 20010000 80000000
00000001
00000000 00001234
00000000

/* apu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module apu_top #(
	parameter int data_w  = apu_cfg_pkg::data_w,
	parameter int prog_aw = apu_cfg_pkg::prog_aw,
	parameter int dat_aw  = apu_cfg_pkg::dat_aw,
	parameter int reg_aw  = apu_cfg_pkg::reg_aw,
	parameter int cnt_w   = apu_cfg_pkg::cnt_w
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   prog_we,	// Only while busy is low
	input  logic [prog_aw-1:0]     prog_addr,
	input  apu_isa_pkg::apu_insn_t prog_data,
	input  logic                   start,
	output logic                   busy,
	output logic                   done,
	input  logic [dat_aw-1:0]      dat_raddr,
	output logic [data_w-1:0]      dat_rdata,	// One cycle after dat_raddr
	output logic [3:0]             flags
);
	import apu_isa_pkg::*;

	apu_insn_t          insn;
	logic [prog_aw-1:0] pc;
	logic               reg_we;
	logic               dat_we;
	logic               use_imm;
	logic               c_in;
	logic               cnt_load;
	logic               cnt_dec;
	logic               cnt_zero;
	apu_func_e          alu_func;
	apu_sz_e            alu_sz;
	logic [data_w-1:0]  ra;
	logic [data_w-1:0]  rb;
	logic [data_w-1:0]  arg1;
	logic [data_w-1:0]  alu_res;
	logic               alu_fc;
	logic               alu_fz;
	logic               alu_fs;
	logic               alu_fv;

	// Immediate is zero-extended
	assign arg1 = use_imm ? data_w'(insn.imm) : rb;

	apu_seq #(.prog_aw(prog_aw)) seq_inst (
		.clk, .rst_n, .start, .insn, .cnt_zero,
		.alu_fc, .alu_fz, .alu_fs, .alu_fv,
		.pc, .busy, .done, .reg_we, .alu_func, .alu_sz, .use_imm, .c_in,
		.cnt_load, .cnt_dec, .dat_we, .flags
	);

	apu_loop_cnt #(.width(cnt_w)) loop_cnt_inst (
		.clk, .rst_n,
		.load(cnt_load), .dec(cnt_dec), .val(cnt_w'(insn.imm)), .cnt_zero
	);

	apu_regs #(.aw(reg_aw)) regs_inst (
		.clk, .rst_n,
		.we(reg_we), .widx(insn.rd), .wdata(alu_res),
		.ra_idx(insn.rd), .rb_idx(insn.rs), .ra, .rb
	);

	apu_alu alu_inst (
		.arg0(ra), .arg1, .c(c_in), .func(alu_func), .sz(alu_sz),
		.res(alu_res), .fc(alu_fc), .fz(alu_fz), .fs(alu_fs), .fv(alu_fv)
	);

	// Host writes, sequencer reads at pc
	apu_ram #(.word_t(apu_insn_t), .aw(prog_aw)) prog_ram (
		.clk, .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
		.raddr(pc), .rdata(insn)
	);

	// Stores come from rs, host reads results
	apu_ram #(.word_t(logic [data_w-1:0]), .aw(dat_aw)) dat_ram (
		.clk, .we(dat_we), .waddr(insn.imm[dat_aw-1:0]), .wdata(rb),
		.raddr(dat_raddr), .rdata(dat_rdata)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the APU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_apu -o tb_apu_sim

out=$(./obj_dir/tb_apu_sim)
echo "$out"

echo "$out" | grep -qx "STATUS: PASS"

/* tb.f */
apu_cfg_pkg.sv
apu_isa_pkg.sv
apu_alu.sv
apu_ram.sv
apu_regs.sv
apu_loop_cnt.sv
apu_seq.sv
apu_top.sv
tb_apu.sv

/* tb_apu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_apu;
	import apu_cfg_pkg::*;
	import apu_isa_pkg::*;

	localparam int timeout_cycles = 2000;
	localparam int td_words       = 256;
	localparam int dat_words      = 1 << dat_aw;

	logic               clk;
	logic               rst_n;
	logic               prog_we;
	logic [prog_aw-1:0] prog_addr;
	apu_insn_t          prog_data;
	logic               start;
	logic               busy;
	logic               done;
	logic [dat_aw-1:0]  dat_raddr;
	logic [data_w-1:0]  dat_rdata;
	logic [3:0]         flags;

	logic [31:0] td [0:td_words-1];	// Whole test data stream
	logic [31:0] chk_addr [0:dat_words-1];
	logic [31:0] chk_val [0:dat_words-1];
	int          ptr;
	integer      seed;
	int          errors;
	int          passed;
	int          failed;
	int          n_tests;
	bit          timed_out;

	apu_top apu_top_inst (
		.clk, .rst_n, .prog_we, .prog_addr, .prog_data, .start,
		.busy, .done, .dat_raddr, .dat_rdata, .flags
	);

	always #5 clk = ~clk;

	task automatic load_program(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			prog_we   = 1'b1;
			prog_addr = prog_aw'(i);
			prog_data = td[ptr];
			ptr++;
		end
		@(negedge clk);
		prog_we = 1'b0;
	endtask

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (busy !== 1'b1) begin
			$display("ERR busy: expected 0x1, got 0x%h", busy);
			errors++;
		end
	endtask

	task automatic wait_done(output bit got);
		int cycles;
		got    = 1'b0;
		cycles = 0;
		while (!got && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
			if (done === 1'b1) begin
				got = 1'b1;
			end
		end
	endtask

	// Done is a single-cycle pulse
	task automatic check_done_low();
		if (done !== 1'b0) begin
			$display("done pulsed again after the program had ended");
			errors++;
		end
	endtask

	// Reads the checked words back in shuffled order
	task automatic read_back(input int n);
		int order [0:dat_words-1];
		int j;
		int tmp;
		int r;
		for (int i = 0; i < n; i++) begin
			order[i] = i;
		end
		for (int i = n - 1; i > 0; i--) begin
			r        = $random(seed);
			j        = (r & 32'h7fffffff) % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			dat_raddr = chk_addr[order[i]][dat_aw-1:0];
			check_done_low();
			@(negedge clk);	// Registered read
			if (dat_rdata !== chk_val[order[i]]) begin
				$display("ERR dat_rdata at 0x%h: expected 0x%h, got 0x%h",
					chk_addr[order[i]], chk_val[order[i]], dat_rdata);
				errors++;
			end
			check_done_low();
		end
	endtask

	task automatic run_test(input int t);
		int         n_insn;
		int         n_chk;
		int         err_start;
		logic [3:0] exp_flags;
		bit         got_done;
		err_start = errors;
		if (busy !== 1'b0) begin
			$display("ERR busy: expected 0x0, got 0x%h", busy);
			errors++;
		end
		n_insn = int'(td[ptr]);
		ptr++;
		load_program(n_insn);
		n_chk = int'(td[ptr]);
		ptr++;
		for (int i = 0; i < n_chk; i++) begin
			chk_addr[i] = td[ptr];
			chk_val[i]  = td[ptr + 1];
			ptr += 2;
		end
		exp_flags = td[ptr][3:0];	// {C, Z, S, V}
		ptr++;
		pulse_start();
		wait_done(got_done);
		if (!got_done) begin
			$display("test %0d: done never arrived within %0d cycles", t, timeout_cycles);
			timed_out = 1'b1;
			errors++;
		end else begin
			if (busy !== 1'b0) begin
				$display("ERR busy: expected 0x0, got 0x%h", busy);
				errors++;
			end
			if (flags !== exp_flags) begin
				$display("ERR flags: expected 0x%h, got 0x%h", exp_flags, flags);
				errors++;
			end
			read_back(n_chk);
		end
		if (errors == err_start) begin
			passed++;
			$display("test %0d passed", t);
		end else begin
			failed++;
			$display("test %0d failed with %0d errors", t, errors - err_start);
		end
	endtask

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		start     = 1'b0;
		dat_raddr = '0;
		seed      = 9103;
		errors    = 0;
		passed    = 0;
		failed    = 0;
		timed_out = 1'b0;
		$readmemh("apu_testdata.txt", td);
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (busy !== 1'b0) begin
			$display("ERR busy: expected 0x0, got 0x%h", busy);
			errors++;
		end
		if (done !== 1'b0) begin
			$display("ERR done: expected 0x0, got 0x%h", done);
			errors++;
		end
		n_tests = int'(td[0]);
		ptr     = 1;
		for (int t = 0; t < n_tests && !timed_out; t++) begin
			run_test(t);
		end
		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			n_tests, passed, failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
